//--- audio/audio_mixer.sv
// Outputs follow inputs by one clk_sys cycle; o_audio_signed tells the sink how to read them
`timescale 1ns/1ps
`include "astro_settings.svh"

module audio_mixer (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  game_pkg::game_id_t          i_game,
	input  game_pkg::game_feat_t        i_feat,
	input  game_pkg::dip_bank_t         i_dip,
	input  audio_pkg::chip_level_t      i_chip_l,
	input  audio_pkg::chip_level_t      i_chip_r,
	input  audio_pkg::sample_t          i_sample_l,
	input  audio_pkg::sample_t          i_sample_r,
	input  logic                        i_speech_sel,
	output logic [`ASTRO_SAMPLE_W-1:0]  o_audio_l,
	output logic [`ASTRO_SAMPLE_W-1:0]  o_audio_r,
	output logic                        o_audio_signed
);

	// Chip level spread over 15 bits, silence stays 0
	function automatic audio_pkg::sample_t widen(input audio_pkg::chip_level_t c,
		input logic half);
		logic [15:0] w;
		w = {1'b0, c, c, c[5:3]};
		return half ? {1'b0, w[15:1]} : w;
	endfunction

	// Chip plus half sample, clipped to the signed range
	function automatic audio_pkg::sample_t mix_sat(input audio_pkg::sample_t chip,
		input audio_pkg::sample_t samp);
		audio_pkg::mix_t sum;
		sum = audio_pkg::mix_t'({1'b0, chip}) + audio_pkg::mix_t'({samp[15], samp[15], samp[15:1]});
		if (sum > audio_pkg::mix_t'(audio_pkg::SAMPLE_MAX)) begin
			return audio_pkg::SAMPLE_MAX;
		end
		if (sum < audio_pkg::mix_t'(audio_pkg::SAMPLE_MIN)) begin
			return audio_pkg::SAMPLE_MIN;
		end
		return sum[15:0];
	endfunction

	game_pkg::dip0_u    dip0;
	audio_pkg::sample_t chip_l;
	audio_pkg::sample_t chip_r;
	audio_pkg::sample_t route_l;
	audio_pkg::sample_t route_r;
	logic               gorf_cab;

	assign dip0     = i_dip[7:0];
	assign gorf_cab = (i_game == game_pkg::GAME_GORF) && dip0.snd.cabinet_mode;

	// WoW effects are loud, take them down a step
	assign chip_l = widen(i_chip_l, i_game == game_pkg::GAME_WOW);
	assign chip_r = widen(i_chip_r, i_game == game_pkg::GAME_WOW);

	// ==============================
	// Channel routing
	// ==============================
	always_comb begin
		if (gorf_cab) begin
			// One speaker per chip, left shared with speech
			route_r = chip_r;
			route_l = i_speech_sel ? i_sample_l : chip_l;
		end else if (i_feat.plus_samples) begin
			route_l = mix_sat(chip_l, i_sample_l);
			route_r = mix_sat(chip_r, i_sample_r);
		end else if (i_feat.stereo) begin
			route_l = chip_l;
			route_r = chip_r;
		end else begin
			// Single chip games are mono
			route_l = chip_l;
			route_r = chip_l;
		end
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			o_audio_l <= '0;
			o_audio_r <= '0;
		end else if (dip0.snd.channel_swap) begin
			o_audio_l <= route_r;
			o_audio_r <= route_l;
		end else begin
			o_audio_l <= route_l;
			o_audio_r <= route_r;
		end
	end

	// Chip-only output is unsigned
	assign o_audio_signed = i_feat.plus_samples;

endmodule

//--- common/astro_settings.svh
// Widths and download indexes are fixed by the core's host interface and must not be changed alone
`ifndef ASTRO_SETTINGS_SVH
`define ASTRO_SETTINGS_SVH

// ==============================
// Download port
// ==============================
// Index carrying the game number
`define ASTRO_DL_INDEX_GAME 1
// Index carrying the DIP switch bank
`define ASTRO_DL_INDEX_DIP 254

// ==============================
// Datapath widths and depths
// ==============================
// Sound chip level per channel
`define ASTRO_CHIP_W 6
// Speech and sample words, signed
`define ASTRO_SAMPLE_W 16
// Bytes in the DIP bank
`define ASTRO_DIP_BYTES 8
// Cabinet lamps on the latch bus
`define ASTRO_LAMP_COUNT 8
// Clocks per lamp bus step
`define ASTRO_LAMP_TICK_DIV 4

`endif

//--- common/audio_pkg.sv
// Chip levels are unsigned with silence at zero; samples are two's complement
`include "astro_settings.svh"

package audio_pkg;

	// ==============================
	// Mixer word types
	// ==============================

	// Raw level from one sound chip channel
	typedef logic [`ASTRO_CHIP_W-1:0] chip_level_t;

	// Speech or sample word, also the output word
	typedef logic signed [`ASTRO_SAMPLE_W-1:0] sample_t;

	// One guard bit for the sum before clipping
	typedef logic signed [`ASTRO_SAMPLE_W:0] mix_t;

	// Full scale limits of the output word
	localparam sample_t SAMPLE_MAX = {1'b0, {(`ASTRO_SAMPLE_W-1){1'b1}}};
	localparam sample_t SAMPLE_MIN = {1'b1, {(`ASTRO_SAMPLE_W-1){1'b0}}};

endpackage

//--- common/game_pkg.sv
// Only game numbers 3 to 6 are supported; every other number decodes as GAME_NONE
`include "astro_settings.svh"

package game_pkg;

	// Game numbers as sent on the download port
	typedef enum logic [7:0] {
		GAME_NONE     = 8'd0,
		GAME_SPACEZAP = 8'd3,
		GAME_GORF     = 8'd4,
		GAME_WOW      = 8'd5,
		GAME_ROBBY    = 8'd6
	} game_id_t;

	// Capability flags per game
	typedef struct packed {
		logic stereo;
		logic plus_samples;
		logic lamps;
	} game_feat_t;

	// DIP byte 0 as seen by the mixer
	typedef struct packed {
		logic [5:0] rsvd;
		logic       channel_swap;
		logic       cabinet_mode;
	} dip0_audio_t;

	// DIP byte 0 as seen by the switch matrix
	typedef struct packed {
		logic [5:0] rsvd;
		logic       p2_alt;
		logic       p1_alt;
	} dip0_input_t;

	// Same byte, meaning depends on the reader
	typedef union packed {
		dip0_audio_t snd;
		dip0_input_t joy;
	} dip0_u;

	// Byte n sits at bits 8n+7 down to 8n
	typedef logic [`ASTRO_DIP_BYTES*8-1:0] dip_bank_t;

endpackage

//--- files.f
+incdir+common
common/game_pkg.sv
common/audio_pkg.sv
src/game_config.sv
src/switch_matrix.sv
audio/audio_mixer.sv
src/lamp_serializer.sv
src/astro_glue_top.sv
tests/tb_astro_glue.sv

//--- src/astro_glue_top.sv
// All logic runs on clk_sys; the core's column select and lamps must be synchronous to it
`timescale 1ns/1ps
`include "astro_settings.svh"

module astro_glue_top (
	input  logic                                  clk_sys,
	input  logic                                  reset,
	// Host download port
	input  logic                                  i_dl_wr,
	input  logic [7:0]                            i_dl_index,
	input  logic [7:0]                            i_dl_addr,
	input  logic [7:0]                            i_dl_data,
	// Switch matrix
	input  logic [7:0]                            i_col_select,
	input  logic [15:0]                           i_joy_p1,
	input  logic [15:0]                           i_joy_p2,
	input  logic                                  i_speech_busy,
	output logic [7:0]                            o_row_data,
	// Audio
	input  audio_pkg::chip_level_t                i_chip_l,
	input  audio_pkg::chip_level_t                i_chip_r,
	input  audio_pkg::sample_t                    i_sample_l,
	input  audio_pkg::sample_t                    i_sample_r,
	input  logic                                  i_speech_sel,
	output logic [`ASTRO_SAMPLE_W-1:0]            o_audio_l,
	output logic [`ASTRO_SAMPLE_W-1:0]            o_audio_r,
	output logic                                  o_audio_signed,
	// Cabinet lamps
	input  logic [`ASTRO_LAMP_COUNT-1:0]          i_lamps,
	output logic [$clog2(`ASTRO_LAMP_COUNT)-1:0]  o_lamp_addr,
	output logic                                  o_lamp_data,
	output logic                                  o_lamp_wr_n
);

	game_pkg::game_id_t   game;
	game_pkg::dip_bank_t  dip;
	game_pkg::game_feat_t feat;

	// Configuration store feeds the three consumers
	game_config u_config (.clk_sys(clk_sys), .reset(reset), .i_dl_wr(i_dl_wr),
		.i_dl_index(i_dl_index), .i_dl_addr(i_dl_addr), .i_dl_data(i_dl_data),
		.o_game(game), .o_dip(dip), .o_feat(feat));

	switch_matrix u_switch (.i_game(game), .i_dip(dip), .i_col_select(i_col_select),
		.i_joy_p1(i_joy_p1), .i_joy_p2(i_joy_p2), .i_speech_busy(i_speech_busy),
		.o_row_data(o_row_data));

	audio_mixer u_mixer (.clk_sys(clk_sys), .reset(reset), .i_game(game), .i_feat(feat),
		.i_dip(dip), .i_chip_l(i_chip_l), .i_chip_r(i_chip_r), .i_sample_l(i_sample_l),
		.i_sample_r(i_sample_r), .i_speech_sel(i_speech_sel), .o_audio_l(o_audio_l),
		.o_audio_r(o_audio_r), .o_audio_signed(o_audio_signed));

	lamp_serializer u_lamps (.clk_sys(clk_sys), .reset(reset), .i_feat(feat),
		.i_lamps(i_lamps), .o_lamp_addr(o_lamp_addr), .o_lamp_data(o_lamp_data),
		.o_lamp_wr_n(o_lamp_wr_n));

endmodule

//--- src/game_config.sv
// Host writes are single strobes without back-pressure; DIP addresses of 8 and above are dropped
`timescale 1ns/1ps
`include "astro_settings.svh"

module game_config (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   i_dl_wr,
	input  logic [7:0]             i_dl_index,
	input  logic [7:0]             i_dl_addr,
	input  logic [7:0]             i_dl_data,
	output game_pkg::game_id_t     o_game,
	output game_pkg::dip_bank_t    o_dip,
	output game_pkg::game_feat_t   o_feat
);

	game_pkg::game_id_t  game_q;
	game_pkg::game_id_t  game_d;
	game_pkg::dip_bank_t dip_q;
	logic                wr_game;
	logic                wr_dip;

	// Strobe decode
	assign wr_game = i_dl_wr && (i_dl_index == 8'(`ASTRO_DL_INDEX_GAME));
	assign wr_dip  = i_dl_wr && (i_dl_index == 8'(`ASTRO_DL_INDEX_DIP)) &&
		(i_dl_addr < 8'(`ASTRO_DIP_BYTES));

	// Unknown numbers fall back to no game
	always_comb begin
		case (i_dl_data)
			8'd3:    game_d = game_pkg::GAME_SPACEZAP;
			8'd4:    game_d = game_pkg::GAME_GORF;
			8'd5:    game_d = game_pkg::GAME_WOW;
			8'd6:    game_d = game_pkg::GAME_ROBBY;
			default: game_d = game_pkg::GAME_NONE;
		endcase
	end

	// ==============================
	// Configuration store
	// ==============================
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			game_q <= game_pkg::GAME_NONE;
			dip_q  <= '0;
		end else begin
			if (wr_game) begin
				game_q <= game_d;
			end
			// One byte lane per strobe
			if (wr_dip) begin
				dip_q[i_dl_addr[2:0]*8 +: 8] <= i_dl_data;
			end
		end
	end

	// Flags follow the stored game, no extra delay
	always_comb begin
		o_feat = '0;
		case (game_q)
			game_pkg::GAME_GORF: begin
				o_feat.stereo       = 1'b1;
				o_feat.plus_samples = 1'b1;
				o_feat.lamps        = 1'b1;
			end
			game_pkg::GAME_WOW: begin
				o_feat.stereo       = 1'b1;
				o_feat.plus_samples = 1'b1;
			end
			// Two chips and the ranking lamps, no speech
			game_pkg::GAME_ROBBY: begin
				o_feat.stereo = 1'b1;
				o_feat.lamps  = 1'b1;
			end
			default: o_feat = '0;
		endcase
	end

	assign o_game = game_q;
	assign o_dip  = dip_q;

endmodule

//--- src/lamp_serializer.sv
// Lamp changes between steps are merged; only the latest value per lamp reaches the latch
`timescale 1ns/1ps
`include "astro_settings.svh"

module lamp_serializer (
	input  logic                                  clk_sys,
	input  logic                                  reset,
	input  game_pkg::game_feat_t                  i_feat,
	input  logic [`ASTRO_LAMP_COUNT-1:0]          i_lamps,
	output logic [$clog2(`ASTRO_LAMP_COUNT)-1:0]  o_lamp_addr,
	output logic                                  o_lamp_data,
	output logic                                  o_lamp_wr_n
);

	localparam int LAMPS = `ASTRO_LAMP_COUNT;
	localparam int DIV   = `ASTRO_LAMP_TICK_DIV;
	localparam int AW    = $clog2(LAMPS);

	// Lowest changed lamp wins
	function automatic logic [AW-1:0] lowest_set(input logic [LAMPS-1:0] bits);
		logic [AW-1:0] idx;
		idx = '0;
		for (int i = LAMPS - 1; i >= 0; i--) begin
			if (bits[i]) begin
				idx = AW'(i);
			end
		end
		return idx;
	endfunction

	logic [$clog2(DIV)-1:0] div_q;
	logic [LAMPS-1:0]       shadow_q;
	logic [LAMPS-1:0]       diff;
	logic [AW-1:0]          next_idx;
	logic                   tick;
	logic                   step;
	logic                   send;

	// ==============================
	// Step timing
	// ==============================
	assign tick = (div_q == ($clog2(DIV))'(DIV - 1));
	assign step = tick && i_feat.lamps;

	assign diff     = shadow_q ^ i_lamps;
	assign next_idx = lowest_set(diff);
	assign send     = step && o_lamp_wr_n && (|diff);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			div_q       <= '0;
			shadow_q    <= '1;
			o_lamp_wr_n <= 1'b1;
		end else begin
			div_q <= tick ? '0 : div_q + 1'b1;
			// Write low for a single step
			if (step && !o_lamp_wr_n) begin
				o_lamp_wr_n <= 1'b1;
			end else if (send) begin
				shadow_q[next_idx] <= i_lamps[next_idx];
				o_lamp_wr_n        <= 1'b0;
			end
		end
	end

	// Address and data hold through the low phase
	always_ff @(posedge clk_sys) begin
		if (send) begin
			o_lamp_addr <= next_idx;
			o_lamp_data <= i_lamps[next_idx];
		end
	end

endmodule

//--- src/switch_matrix.sv
// Purely combinational; joystick bits are active high in and rows are active low out
`timescale 1ns/1ps

module switch_matrix (
	input  game_pkg::game_id_t  i_game,
	input  game_pkg::dip_bank_t i_dip,
	input  logic [7:0]          i_col_select,
	input  logic [15:0]         i_joy_p1,
	input  logic [15:0]         i_joy_p2,
	input  logic                i_speech_busy,
	output logic [7:0]          o_row_data
);

	game_pkg::dip0_u dip0;
	logic [7:0]      dip2;
	logic [7:0]      dip3;
	logic [7:0]      col1;
	logic [7:0]      col2;
	logic [7:0]      col4;
	logic [4:0]      p1_stick;
	logic [4:0]      p2_stick;
	logic            p1_fire_b;
	logic            p2_fire_b;
	logic            coin1;
	logic            coin2;
	logic            start1;
	logic            start2;

	assign dip0 = i_dip[7:0];
	assign dip2 = i_dip[23:16];
	assign dip3 = i_dip[31:24];

	// Fire, right, left, down, up, already inverted
	assign p1_stick = ~i_joy_p1[4:0];
	assign p2_stick = ~i_joy_p2[4:0];

	// Both starts and both coins sit on pad 1
	assign start1 = i_joy_p1[6];
	assign start2 = i_joy_p1[7];
	assign coin1  = i_joy_p1[8];
	assign coin2  = i_joy_p1[9];

	// WoW move button, polarity set per player by DIP 0
	assign p1_fire_b = dip0.joy.p1_alt ? i_joy_p1[5] : ~i_joy_p1[5];
	assign p2_fire_b = dip0.joy.p2_alt ? i_joy_p2[5] : ~i_joy_p2[5];

	// ==============================
	// Per-game row layouts
	// ==============================
	always_comb begin
		col1 = 8'hFF;
		col2 = 8'hFF;
		col4 = 8'hFF;
		case (i_game)
			game_pkg::GAME_SPACEZAP: begin
				col1 = {2'b11, ~start2, ~start1, dip2[1], 1'b1, ~coin1, 1'b1};
				col2 = {3'b111, p2_stick};
				col4 = {2'b11, dip2[0], p1_stick};
			end
			game_pkg::GAME_GORF: begin
				// Slam switch held open, test switch from DIP 2
				col1 = {dip2[2], dip2[0], ~start2, ~start1, 1'b1, dip2[1], ~coin2, ~coin1};
				col2 = {3'b001, p2_stick};
				col4 = {i_speech_busy, 2'b01, p1_stick};
			end
			game_pkg::GAME_WOW: begin
				col1 = {dip2[2], ~start2, ~start1, 1'b1, dip2[1], 1'b1, ~coin1, 1'b1};
				col2 = {2'b11, p2_stick[4], p2_fire_b, p2_stick[3:0]};
				col4 = {i_speech_busy, 1'b1, p1_stick[4], p1_fire_b, p1_stick[3:0]};
			end
			game_pkg::GAME_ROBBY: begin
				col1 = {1'b0, ~start2, ~start1, 1'b1, dip2[1], 1'b1, ~coin1, 1'b1};
				col2 = {2'b11, p2_stick[4], 1'b1, p2_stick[3:0]};
				col4 = {2'b11, p1_stick[4], 1'b1, p1_stick[3:0]};
			end
			default: begin
				col1 = 8'hFF;
				col2 = 8'hFF;
				col4 = 8'hFF;
			end
		endcase
	end

	// Column select from the core, one-hot
	always_comb begin
		case (i_col_select)
			8'h01:   o_row_data = col1;
			8'h02:   o_row_data = col2;
			8'h04:   o_row_data = col4;
			8'h08:   o_row_data = (i_game == game_pkg::GAME_NONE) ? 8'hFF : dip3;
			default: o_row_data = 8'hFF;
		endcase
	end

endmodule

//--- tests/tb_astro_glue.sv
// Reaches the DUT only through its ports; lamp pulse widths assume a lamp step of 4 clocks
`timescale 1ns/1ps
`include "astro_settings.svh"

module tb_astro_glue;

	logic               clk_sys;
	logic               reset;
	logic               i_dl_wr;
	logic [7:0]         i_dl_index;
	logic [7:0]         i_dl_addr;
	logic [7:0]         i_dl_data;
	logic [7:0]         i_col_select;
	logic [15:0]        i_joy_p1;
	logic [15:0]        i_joy_p2;
	logic               i_speech_busy;
	logic [7:0]         o_row_data;
	logic [5:0]         i_chip_l;
	logic [5:0]         i_chip_r;
	logic signed [15:0] i_sample_l;
	logic signed [15:0] i_sample_r;
	logic               i_speech_sel;
	logic [15:0]        o_audio_l;
	logic [15:0]        o_audio_r;
	logic               o_audio_signed;
	logic [7:0]         i_lamps;
	logic [2:0]         o_lamp_addr;
	logic               o_lamp_data;
	logic               o_lamp_wr_n;
	integer             seed = 29705;
	// Observed lamp writes as {data, addr}
	logic [3:0]         pulse_q[$];
	int                 low_cycles = 0;
	int                 high_cycles = 8;

	astro_glue_top uut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	task automatic mismatch(input string msg);
		$display("MISMATCH at %0t ns: %s", $time, msg);
		$display("Simulation failed");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic timed_out(input string what);
		$display("Timed out while waiting for %s", what);
		$display("Simulation failed");
		$fatal(1, "Stopped on a timeout");
	endtask

	// ==============================
	// Reference models
	// ==============================
	// Chip level spread as 0 then c then c then the top three bits of c
	function automatic int chip_word(input logic [5:0] c, input logic half);
		int w;
		w = c * 512 + c * 8 + c / 8;
		return half ? w / 2 : w;
	endfunction

	function automatic int clip(input int v);
		if (v > 32767) return 32767;
		if (v < -32768) return -32768;
		return v;
	endfunction

	// One download strobe with the result visible at the returning falling edge
	task automatic dl_write(input logic [7:0] index, input logic [7:0] addr,
		input logic [7:0] data);
		@(negedge clk_sys);
		i_dl_wr    = 1'b1;
		i_dl_index = index;
		i_dl_addr  = addr;
		i_dl_data  = data;
		@(negedge clk_sys);
		i_dl_wr = 1'b0;
	endtask

	task automatic configure(input logic [7:0] game, input logic [7:0] dip0,
		input logic [7:0] dip2, input logic [7:0] dip3);
		dl_write(8'(`ASTRO_DL_INDEX_GAME), 8'd0, game);
		dl_write(8'(`ASTRO_DL_INDEX_DIP), 8'd0, dip0);
		dl_write(8'(`ASTRO_DL_INDEX_DIP), 8'd2, dip2);
		dl_write(8'(`ASTRO_DL_INDEX_DIP), 8'd3, dip3);
	endtask

	// Column driven on a falling edge and sampled once the rows settle
	task automatic check_row(input logic [7:0] col, input logic [7:0] exp,
		input logic [7:0] mask, input string what);
		i_col_select = col;
		#1;
		assert ((o_row_data & mask) == (exp & mask)) else
			mismatch($sformatf("%s: column %02h gave %02h, expected %02h", what, col,
				o_row_data, exp));
		@(negedge clk_sys);
	endtask

	task automatic drive_audio(input logic sel);
		@(negedge clk_sys);
		i_chip_l     = 6'($random(seed));
		i_chip_r     = 6'($random(seed));
		i_sample_l   = 16'($random(seed));
		i_sample_r   = 16'($random(seed));
		i_speech_sel = sel;
	endtask

	// Registered mixer output is read at the next falling edge
	task automatic check_audio(input int exp_l, input int exp_r, input string what);
		@(negedge clk_sys);
		assert (o_audio_l == 16'(exp_l) && o_audio_r == 16'(exp_r)) else
			mismatch($sformatf("%s: audio %04h/%04h, expected %04h/%04h", what, o_audio_l,
				o_audio_r, 16'(exp_l), 16'(exp_r)));
	endtask

	// ==============================
	// Lamp bus monitor
	// ==============================
	always @(negedge clk_sys) begin
		if (!reset && o_lamp_wr_n === 1'b0) begin
			if (low_cycles == 0) begin
				assert (high_cycles >= 4) else mismatch("lamp write high for less than a step");
				pulse_q.push_back({o_lamp_data, o_lamp_addr});
			end
			low_cycles++;
			high_cycles = 0;
		end else begin
			if (low_cycles != 0) begin
				assert (low_cycles == 4) else
					mismatch($sformatf("lamp write low for %0d clocks", low_cycles));
			end
			low_cycles = 0;
			high_cycles++;
		end
	end

	// Expected writes are the changed bits in ascending address order
	task automatic lamp_change(input logic [7:0] lamps);
		logic [3:0] expect_q[$];
		int         guard;
		guard = 0;
		pulse_q.delete();
		@(negedge clk_sys);
		for (int i = 0; i < 8; i++)
			if (lamps[i] != i_lamps[i]) expect_q.push_back({lamps[i], 3'(i)});
		i_lamps = lamps;
		while (pulse_q.size() < expect_q.size() || !o_lamp_wr_n) begin
			@(negedge clk_sys);
			guard++;
			if (guard > 200) timed_out("lamp writes");
		end
		assert (pulse_q.size() == expect_q.size()) else
			mismatch($sformatf("%0d lamp writes, expected %0d", pulse_q.size(), expect_q.size()));
		foreach (expect_q[k])
			assert (pulse_q[k] == expect_q[k]) else
				mismatch($sformatf("lamp write %0d was %h, expected %h", k, pulse_q[k],
					expect_q[k]));
	endtask

	task automatic expect_quiet(input string what);
		pulse_q.delete();
		repeat (40) @(negedge clk_sys);
		assert (pulse_q.size() == 0 && o_lamp_wr_n) else
			mismatch($sformatf("%s: unexpected lamp write", what));
	endtask

	initial begin
		logic [7:0]  bad_ids [3];
		logic [15:0] joy;
		logic        busy;
		bad_ids = '{8'd1, 8'd2, 8'd7};
		reset = 1'b1;
		i_dl_wr = 1'b0;
		i_dl_index = 8'd0;
		i_dl_addr = 8'd0;
		i_dl_data = 8'd0;
		i_col_select = 8'd0;
		i_joy_p1 = 16'd0;
		i_joy_p2 = 16'd0;
		i_speech_busy = 1'b0;
		i_chip_l = 6'd0;
		i_chip_r = 6'd0;
		i_sample_l = 16'sd0;
		i_sample_r = 16'sd0;
		i_speech_sel = 1'b0;
		i_lamps = 8'hFF;
		repeat (5) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;

		// Reset state with no game loaded
		assert (o_lamp_wr_n && o_audio_l == 16'd0 && o_audio_r == 16'd0) else
			mismatch("lamp write or audio not idle after reset");
		for (int c = 0; c < 256; c++) check_row(8'(c), 8'hFF, 8'hFF, "after reset");

		// Configuration load followed by unsupported game numbers
		configure(8'd4, 8'h00, 8'h00, 8'h5A);
		check_row(8'h08, 8'h5A, 8'hFF, "DIP byte 3");
		foreach (bad_ids[g]) begin
			configure(bad_ids[g], 8'h00, 8'h00, 8'hC3);
			for (int c = 0; c < 256; c++) check_row(8'(c), 8'hFF, 8'hFF, "unsupported game");
		end

		// ==============================
		// Switch matrix
		// ==============================
		for (int dz = 0; dz < 2; dz++) begin
			configure(8'd3, 8'h00, 8'(dz), 8'h00);
			repeat (8) begin
				joy = 16'($random(seed));
				@(negedge clk_sys);
				i_joy_p1 = joy;
				check_row(8'h04, {2'b11, 1'(dz), ~joy[4:0]}, 8'hFF, "Space Zap stick");
			end
		end
		configure(8'd4, 8'h00, 8'h00, 8'h00);
		repeat (16) begin
			joy = 16'($random(seed));
			busy = 1'($random(seed));
			@(negedge clk_sys);
			i_joy_p1 = joy;
			i_speech_busy = busy;
			check_row(8'h04, {busy, 2'b00, ~joy[4:0]}, 8'h9F, "Gorf stick");
		end
		for (int alt = 0; alt < 2; alt++) begin
			configure(8'd5, 8'(alt), 8'h00, 8'h00);
			repeat (8) begin
				joy = 16'($random(seed));
				busy = 1'($random(seed));
				@(negedge clk_sys);
				i_joy_p1 = joy;
				i_speech_busy = busy;
				check_row(8'h04, {busy, 2'b00, alt ? joy[5] : ~joy[5], ~joy[3:0]}, 8'h9F,
					"Wizard of Wor fire B");
			end
		end

		// Mixing and clipping
		configure(8'd4, 8'h00, 8'h00, 8'h00);
		repeat (20) begin
			drive_audio(1'b0);
			check_audio(clip(chip_word(i_chip_l, 1'b0) + (int'(i_sample_l) >>> 1)),
				clip(chip_word(i_chip_r, 1'b0) + (int'(i_sample_r) >>> 1)), "Gorf mix");
		end
		assert (o_audio_signed) else mismatch("Gorf output not flagged signed");
		@(negedge clk_sys);
		i_chip_l = 6'd63;
		i_chip_r = 6'd63;
		i_sample_l = 16'sh7FFF;
		i_sample_r = 16'sh7FFF;
		check_audio(32767, 32767, "positive clip");
		configure(8'd5, 8'h00, 8'h00, 8'h00);
		repeat (10) begin
			drive_audio(1'b0);
			check_audio(clip(chip_word(i_chip_l, 1'b1) + (int'(i_sample_l) >>> 1)),
				clip(chip_word(i_chip_r, 1'b1) + (int'(i_sample_r) >>> 1)), "Wizard of Wor mix");
		end

		// ==============================
		// Routing
		// ==============================
		configure(8'd6, 8'h00, 8'h00, 8'h00);
		drive_audio(1'b0);
		check_audio(chip_word(i_chip_l, 1'b0), chip_word(i_chip_r, 1'b0), "Robby stereo");
		assert (!o_audio_signed) else mismatch("Robby output flagged signed");
		configure(8'd4, 8'h01, 8'h00, 8'h00);
		for (int sel = 0; sel < 2; sel++) begin
			drive_audio(1'(sel));
			check_audio(sel ? int'(i_sample_l) : chip_word(i_chip_l, 1'b0),
				chip_word(i_chip_r, 1'b0), "Gorf cabinet");
		end
		configure(8'd4, 8'h02, 8'h00, 8'h00);
		drive_audio(1'b0);
		check_audio(clip(chip_word(i_chip_r, 1'b0) + (int'(i_sample_r) >>> 1)),
			clip(chip_word(i_chip_l, 1'b0) + (int'(i_sample_l) >>> 1)), "channel swap");
		configure(8'd3, 8'h00, 8'h00, 8'h00);
		drive_audio(1'b0);
		check_audio(chip_word(i_chip_l, 1'b0), chip_word(i_chip_l, 1'b0), "Space Zap mono");
		assert (!o_audio_signed) else mismatch("Space Zap output flagged signed");

		// Lamp writes under Gorf and none under Space Zap
		configure(8'd4, 8'h00, 8'h00, 8'h00);
		lamp_change(8'hA6);
		lamp_change(8'hE7);
		expect_quiet("Gorf with no change");
		configure(8'd3, 8'h00, 8'h00, 8'h00);
		@(negedge clk_sys);
		i_lamps = 8'h00;
		expect_quiet("Space Zap lamps");

		$display("Simulation completed successfully");
		$finish;
	end

endmodule
